// ==== hdl/bp_pkg.sv ====
package bp_pkg;

    // default sizes, overridden from the top level
    localparam int PC_SIZE_DEF    = 8;
    localparam int TABLE_BITS_DEF = 4;

    // every counter starts at weakly taken
    localparam logic [1:0] WEAK_TAKEN = 2'd2;

    // major opcodes, RISC-V encoding; anything else is a no-op
    typedef enum logic [6:0] {
        OP_ADDI   = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // branch funct3 values
    typedef enum logic [2:0] {
        BR_EQ = 3'b000,
        BR_NE = 3'b001,
        BR_LT = 3'b100
    } branch_cond_e;

endpackage

// ==== hdl/branch_resolver.sv ====
module branch_resolver
    import bp_pkg::*;
#(
    parameter int PC_SIZE = PC_SIZE_DEF
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               buf_valid,
    input  logic [PC_SIZE-1:0] buf_pc,
    input  logic [31:0]        buf_instr,
    output logic               should_have_jumped,
    output logic               commit_valid,
    output logic [PC_SIZE-1:0] commit_pc,
    output logic [2:0]         commit_rd,
    output logic [31:0]        commit_value,
    output logic               commit_wen
);

    logic [31:0]        regs [8];
    opcode_e            op;
    branch_cond_e       cond;
    logic [2:0]         rd;
    logic [2:0]         rs1;
    logic [2:0]         rs2;
    logic [31:0]        i_imm;
    logic [31:0]        rs1_val;
    logic [31:0]        rs2_val;
    logic [PC_SIZE-1:0] link_pc;
    logic               cond_true;
    logic               writes_rd;

    // only the low three bits of each register field are decoded
    assign op    = opcode_e'(buf_instr[6:0]);
    assign cond  = branch_cond_e'(buf_instr[14:12]);
    assign rd    = buf_instr[9:7];
    assign rs1   = buf_instr[17:15];
    assign rs2   = buf_instr[22:20];
    assign i_imm = {{20{buf_instr[31]}}, buf_instr[31:20]};

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];
    assign link_pc = buf_pc + PC_SIZE'(1);

    always_comb begin
        case (cond)
            BR_EQ:   cond_true = (rs1_val == rs2_val);
            BR_NE:   cond_true = (rs1_val != rs2_val);
            BR_LT:   cond_true = ($signed(rs1_val) < $signed(rs2_val));
            default: cond_true = 1'b0;
        endcase
    end

    // bubbles never count as taken
    assign should_have_jumped = buf_valid &&
                                ((op == OP_JAL) || (op == OP_BRANCH && cond_true));

    always_comb begin
        case (op)
            OP_ADDI: begin
                writes_rd    = 1'b1;
                commit_value = rs1_val + i_imm;
            end
            OP_JAL: begin
                writes_rd    = 1'b1;
                commit_value = {{(32 - PC_SIZE){1'b0}}, link_pc};
            end
            default: begin
                writes_rd    = 1'b0;
                commit_value = '0;
            end
        endcase
    end

    assign commit_valid = buf_valid;
    assign commit_pc    = buf_pc;
    assign commit_rd    = rd;
    // x0 is never written
    assign commit_wen   = buf_valid && writes_rd && (rd != 3'd0);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_wen) begin
            regs[rd] <= commit_value;
        end
    end

endmodule

// ==== hdl/fetch_buffer.sv ====
module fetch_buffer
    import bp_pkg::*;
#(
    parameter int PC_SIZE = PC_SIZE_DEF
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               run,
    input  logic               force_nop,
    input  logic [PC_SIZE-1:0] current_pc,
    input  logic [31:0]        fetch_instr,
    output logic               buf_valid,
    output logic [PC_SIZE-1:0] buf_pc,
    output logic [31:0]        buf_instr
);

    // flush turns the captured fetch into a bubble
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid <= 1'b0;
        end else begin
            buf_valid <= run && !force_nop;
        end
    end

    always_ff @(posedge CLK) begin
        buf_pc    <= current_pc;
        buf_instr <= fetch_instr;
    end

endmodule

// ==== hdl/fetch_unit.sv ====
module fetch_unit
    import bp_pkg::*;
#(
    parameter int PC_SIZE = PC_SIZE_DEF
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               run,
    input  logic [31:0]        rom_data,
    input  logic [PC_SIZE-1:0] predictor_jump_pc,
    output logic [PC_SIZE-1:0] rom_addr,
    output opcode_e            opcode,
    output logic [PC_SIZE-1:0] current_pc,
    output logic [PC_SIZE-1:0] next_consecutive_pc,
    output logic [PC_SIZE-1:0] jump_pc,
    output logic [31:0]        fetch_instr
);

    logic [PC_SIZE-1:0] pc;
    opcode_e            raw_opcode;
    logic [31:0]        b_offset;
    logic [31:0]        j_offset;
    logic [31:0]        offset;

    // pc follows the predictor every cycle while running
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= predictor_jump_pc;
        end
    end

    assign rom_addr    = pc;
    assign current_pc  = pc;
    assign fetch_instr = rom_data;

    assign raw_opcode = opcode_e'(fetch_instr[6:0]);

    // idle fetch must not look like a jump to the predictor
    assign opcode = run ? raw_opcode : opcode_e'(7'd0);

    // RISC-V immediate layout, value counted in instructions
    assign b_offset = {{20{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                       fetch_instr[30:25], fetch_instr[11:8]};
    assign j_offset = {{12{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                       fetch_instr[20], fetch_instr[30:21]};

    assign offset = (raw_opcode == OP_JAL) ? j_offset : b_offset;

    assign next_consecutive_pc = pc + PC_SIZE'(1);
    assign jump_pc             = pc + offset[PC_SIZE-1:0];

endmodule

// ==== hdl/frontend_top.sv ====
module frontend_top
    import bp_pkg::*;
#(
    parameter int PC_SIZE    = PC_SIZE_DEF,
    parameter int TABLE_BITS = TABLE_BITS_DEF
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               run,
    input  logic               prog_we,
    input  logic [PC_SIZE-1:0] prog_addr,
    input  logic [31:0]        prog_data,
    output logic               mispredict,
    output logic               commit_valid,
    output logic [PC_SIZE-1:0] commit_pc,
    output logic [2:0]         commit_rd,
    output logic [31:0]        commit_value,
    output logic               commit_wen
);

    logic [PC_SIZE-1:0] rom_addr;
    logic [31:0]        rom_data;
    opcode_e            opcode;
    logic [PC_SIZE-1:0] current_pc;
    logic [PC_SIZE-1:0] next_consecutive_pc;
    logic [PC_SIZE-1:0] jump_pc;
    logic [31:0]        fetch_instr;
    logic [PC_SIZE-1:0] predictor_jump_pc;
    logic               force_nop;
    logic               should_have_jumped;
    logic               buf_valid;
    logic [PC_SIZE-1:0] buf_pc;
    logic [31:0]        buf_instr;

    assign mispredict = force_nop;

    instr_rom #(.PC_SIZE(PC_SIZE)) rom_i (
        .CLK       (CLK),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data)
    );

    fetch_unit #(.PC_SIZE(PC_SIZE)) fetch_i (
        .CLK                 (CLK),
        .rst_n               (rst_n),
        .run                 (run),
        .rom_data            (rom_data),
        .predictor_jump_pc   (predictor_jump_pc),
        .rom_addr            (rom_addr),
        .opcode              (opcode),
        .current_pc          (current_pc),
        .next_consecutive_pc (next_consecutive_pc),
        .jump_pc             (jump_pc),
        .fetch_instr         (fetch_instr)
    );

    // fetch always loads predictor_jump_pc, so do_jump stays open here
    jump_predictor #(.PC_SIZE(PC_SIZE), .TABLE_BITS(TABLE_BITS)) pred_i (
        .CLK                 (CLK),
        .rst_n               (rst_n),
        .opcode              (opcode),
        .current_pc          (current_pc),
        .next_consecutive_pc (next_consecutive_pc),
        .jump_pc             (jump_pc),
        .should_have_jumped  (should_have_jumped),
        .do_jump             (),
        .predictor_jump_pc   (predictor_jump_pc),
        .force_nop           (force_nop)
    );

    fetch_buffer #(.PC_SIZE(PC_SIZE)) buf_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .run         (run),
        .force_nop   (force_nop),
        .current_pc  (current_pc),
        .fetch_instr (fetch_instr),
        .buf_valid   (buf_valid),
        .buf_pc      (buf_pc),
        .buf_instr   (buf_instr)
    );

    branch_resolver #(.PC_SIZE(PC_SIZE)) exec_i (
        .CLK                (CLK),
        .rst_n              (rst_n),
        .buf_valid          (buf_valid),
        .buf_pc             (buf_pc),
        .buf_instr          (buf_instr),
        .should_have_jumped (should_have_jumped),
        .commit_valid       (commit_valid),
        .commit_pc          (commit_pc),
        .commit_rd          (commit_rd),
        .commit_value       (commit_value),
        .commit_wen         (commit_wen)
    );

endmodule

// ==== hdl/instr_rom.sv ====
module instr_rom
    import bp_pkg::*;
#(
    parameter int PC_SIZE = PC_SIZE_DEF
) (
    input  logic               CLK,
    input  logic               prog_we,
    input  logic [PC_SIZE-1:0] prog_addr,
    input  logic [31:0]        prog_data,
    input  logic [PC_SIZE-1:0] rom_addr,
    output logic [31:0]        rom_data
);

    localparam int WORDS = 2 ** PC_SIZE;

    logic [31:0] mem [WORDS];

    // loaded by the testbench while fetch is idle
    always_ff @(posedge CLK) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // fetch sees the word in the same cycle
    assign rom_data = mem[rom_addr];

endmodule

// ==== hdl/jump_predictor.sv ====
module jump_predictor
    import bp_pkg::*;
#(
    parameter int PC_SIZE    = PC_SIZE_DEF,
    parameter int TABLE_BITS = TABLE_BITS_DEF
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  opcode_e            opcode,
    input  logic [PC_SIZE-1:0] current_pc,
    input  logic [PC_SIZE-1:0] next_consecutive_pc,
    input  logic [PC_SIZE-1:0] jump_pc,
    input  logic               should_have_jumped,
    output logic               do_jump,
    output logic [PC_SIZE-1:0] predictor_jump_pc,
    output logic               force_nop
);

    localparam int ENTRIES = 2 ** TABLE_BITS;

    logic [1:0]            counters [ENTRIES];
    logic [TABLE_BITS-1:0] index;
    logic                  is_branch;
    logic                  predict_taken;

    // what was predicted for the instruction now in the buffer
    logic                  prev_taken;
    logic                  prev_branch;
    logic [TABLE_BITS-1:0] prev_index;
    logic [PC_SIZE-1:0]    alt_pc;

    // table indexed by low bits of the target
    assign index     = jump_pc[TABLE_BITS-1:0];
    assign is_branch = (opcode == OP_BRANCH);

    assign predict_taken = (opcode == OP_JAL) ||
                           (is_branch && counters[index] >= 2'd2);

    assign force_nop = (prev_taken != should_have_jumped);
    assign do_jump   = predict_taken || force_nop;

    always_comb begin
        if (force_nop) begin
            predictor_jump_pc = alt_pc;
        end else if (predict_taken) begin
            predictor_jump_pc = jump_pc;
        end else begin
            predictor_jump_pc = next_consecutive_pc;
        end
    end

    // squashed fetch records a not-taken non-branch
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            prev_taken  <= 1'b0;
            prev_branch <= 1'b0;
        end else if (force_nop) begin
            prev_taken  <= 1'b0;
            prev_branch <= 1'b0;
        end else begin
            prev_taken  <= predict_taken;
            prev_branch <= is_branch;
        end
    end

    // address to restart from if this prediction turns out wrong
    always_ff @(posedge CLK) begin
        prev_index <= index;
        alt_pc     <= predict_taken ? current_pc + PC_SIZE'(1) : jump_pc;
    end

    // saturating two-bit update, branches only
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= WEAK_TAKEN;
            end
        end else if (prev_branch) begin
            if (should_have_jumped) begin
                if (counters[prev_index] != 2'd3) begin
                    counters[prev_index] <= counters[prev_index] + 2'd1;
                end
            end else begin
                if (counters[prev_index] != 2'd0) begin
                    counters[prev_index] <= counters[prev_index] - 2'd1;
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing --assert -f verilog.f --top-module tb_top \
    && ./obj_dir/Vtb_top > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== sim/tb_program.svh ====
localparam int WORDS      = 2 ** PC_SIZE;
localparam int RAND_FIRST = 19;
localparam int END_PC     = 59;

// program source fields and the encoded image
opcode_e      tbl_op    [WORDS];
branch_cond_e tbl_cond  [WORDS];
logic [2:0]   tbl_rd    [WORDS];
logic [2:0]   tbl_rs1   [WORDS];
logic [2:0]   tbl_rs2   [WORDS];
int           tbl_imm   [WORDS];
logic [31:0]  prog_word [WORDS];

// reference model state
logic [31:0]           model_regs [8];
logic [1:0]            model_ctr  [2 ** TABLE_BITS];
logic                  pend_valid;
logic [TABLE_BITS-1:0] pend_idx;
logic                  pend_taken;
int                    seed = 32'h98a3c425;

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// offsets count instructions, fields follow the RISC-V layout
task automatic put(input int a, input opcode_e op, input branch_cond_e cond,
                   input int rd, input int rs1, input int rs2, input int imm);
    logic [11:0] b;
    logic [19:0] j;
    b = 12'(imm);
    j = 20'(imm);
    tbl_op[a]   = op;
    tbl_cond[a] = cond;
    tbl_rd[a]   = 3'(rd);
    tbl_rs1[a]  = 3'(rs1);
    tbl_rs2[a]  = 3'(rs2);
    tbl_imm[a]  = imm;
    case (op)
        OP_BRANCH: prog_word[a] = {b[11], b[9:4], 2'b00, 3'(rs2), 2'b00, 3'(rs1), cond,
                                   b[3:0], b[10], op};
        OP_JAL:    prog_word[a] = {j[19], j[9:0], j[10], j[18:11], 2'b00, 3'(rd), op};
        default:   prog_word[a] = {b, 2'b00, 3'(rs1), 3'b000, 2'b00, 3'(rd), op};
    endcase
endtask

task automatic build_program();
    int           a;
    int           off;
    int           imm;
    int           rd;
    int           rs1;
    int           rs2;
    branch_cond_e cond;
    // unused words hold addi x0, x0, addr
    for (a = 0; a < WORDS; a++) begin
        put(a, OP_ADDI, BR_EQ, 0, 0, 0, a);
    end
    put(0, OP_ADDI, BR_EQ, 1, 0, 0, 5);
    put(1, OP_ADDI, BR_EQ, 2, 1, 0, -3);
    put(2, OP_ADDI, BR_EQ, 3, 2, 0, 100);
    put(3, OP_ADDI, BR_EQ, 4, 0, 0, -7);
    // jal skips word 5
    put(4, OP_JAL, BR_EQ, 5, 0, 0, 2);
    put(5, OP_ADDI, BR_EQ, 6, 0, 0, 999);
    put(6, OP_ADDI, BR_EQ, 6, 0, 0, 3);
    // three passes, exit mispredicts
    put(7, OP_ADDI, BR_EQ, 7, 7, 0, 1);
    put(8, OP_ADDI, BR_EQ, 6, 6, 0, -1);
    put(9, OP_BRANCH, BR_NE, 0, 6, 0, -2);
    // signed compares
    put(10, OP_ADDI, BR_EQ, 1, 0, 0, -4);
    put(11, OP_ADDI, BR_EQ, 2, 0, 0, 3);
    put(12, OP_BRANCH, BR_LT, 0, 1, 2, 2);
    put(13, OP_ADDI, BR_EQ, 3, 0, 0, 77);
    put(14, OP_BRANCH, BR_LT, 0, 2, 1, 1);
    // beq counter runs down to 0, blt counter up to 3
    put(15, OP_ADDI, BR_EQ, 4, 0, 0, 5);
    put(16, OP_ADDI, BR_EQ, 4, 4, 0, -1);
    put(17, OP_BRANCH, BR_EQ, 0, 4, 0, 2);
    put(18, OP_BRANCH, BR_LT, 0, 0, 4, -2);
    // random part only branches forward, so it always reaches END_PC
    for (a = RAND_FIRST; a < END_PC; a++) begin
        rs1 = rand_below(8);
        if (rand_below(5) < 3) begin
            rd  = 1 + rand_below(7);
            imm = (rand_below(2) == 0) ? rand_below(16) - 8 : rand_below(4096) - 2048;
            put(a, OP_ADDI, BR_EQ, rd, rs1, 0, imm);
        end else begin
            rs2 = rand_below(8);
            off = 1 + rand_below(3);
            if (a + off > END_PC) begin
                off = END_PC - a;
            end
            case (rand_below(3))
                0:       cond = BR_EQ;
                1:       cond = BR_NE;
                default: cond = BR_LT;
            endcase
            put(a, OP_BRANCH, cond, 0, rs1, rs2, off);
        end
    end
    put(END_PC, OP_JAL, BR_EQ, 0, 0, 0, 0);
endtask

// one instruction of the ISA, returns the next pc
function automatic logic [PC_SIZE-1:0] isa_step(input logic [PC_SIZE-1:0] pc,
        output logic wen, output logic [2:0] rd, output logic [31:0] val,
        output logic taken);
    logic [31:0] a;
    logic [31:0] b;
    a     = model_regs[tbl_rs1[pc]];
    b     = model_regs[tbl_rs2[pc]];
    rd    = tbl_rd[pc];
    wen   = (tbl_op[pc] == OP_ADDI || tbl_op[pc] == OP_JAL) && rd != 3'd0;
    val   = (tbl_op[pc] == OP_JAL) ? {{(32 - PC_SIZE){1'b0}}, pc + PC_SIZE'(1)}
                                   : a + 32'(tbl_imm[pc]);
    taken = (tbl_op[pc] == OP_JAL);
    if (tbl_op[pc] == OP_BRANCH) begin
        case (tbl_cond[pc])
            BR_EQ:   taken = (a == b);
            BR_NE:   taken = (a != b);
            default: taken = ($signed(a) < $signed(b));
        endcase
    end
    return taken ? pc + PC_SIZE'(tbl_imm[pc]) : pc + PC_SIZE'(1);
endfunction

function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
    if (up) begin
        return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
endfunction

// two-bit predictor, true when the instruction at pc is mispredicted
function automatic logic predict_miss(input logic [PC_SIZE-1:0] pc, input logic taken);
    logic [PC_SIZE-1:0]    target;
    logic [TABLE_BITS-1:0] idx;
    logic                  is_br;
    logic                  guess;
    target = pc + PC_SIZE'(tbl_imm[pc]);
    idx    = target[TABLE_BITS-1:0];
    is_br  = (tbl_op[pc] == OP_BRANCH);
    guess  = (tbl_op[pc] == OP_JAL) || (is_br && model_ctr[idx] >= 2'd2);
    // previous branch updates one cycle late, after this lookup
    if (pend_valid) begin
        model_ctr[pend_idx] = sat_step(model_ctr[pend_idx], pend_taken);
    end
    pend_valid = is_br;
    pend_idx   = idx;
    pend_taken = taken;
    // after a redirect the next fetch already sees this update
    if (guess != taken && pend_valid) begin
        model_ctr[idx] = sat_step(model_ctr[idx], taken);
        pend_valid     = 1'b0;
    end
    return guess != taken;
endfunction

// ==== sim/tb_top.sv ====
module tb_top
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PC_SIZE     = PC_SIZE_DEF;
    localparam int TABLE_BITS  = TABLE_BITS_DEF;
    localparam int MAX_COMMITS = 1024;
    localparam int MARGIN      = 16;

    logic               CLK;
    logic               rst_n;
    logic               run;
    logic               prog_we;
    logic [PC_SIZE-1:0] prog_addr;
    logic [31:0]        prog_data;
    logic               mispredict;
    logic               commit_valid;
    logic [PC_SIZE-1:0] commit_pc;
    logic [2:0]         commit_rd;
    logic [31:0]        commit_value;
    logic               commit_wen;

    `include "tb_program.svh"

    logic [PC_SIZE-1:0] exp_pc  [MAX_COMMITS];
    logic               exp_wen [MAX_COMMITS];
    logic [2:0]         exp_rd  [MAX_COMMITS];
    logic [31:0]        exp_val [MAX_COMMITS];
    logic               exp_mis [MAX_COMMITS];
    int                 exp_count;
    int                 exp_mis_total;

    int   cycle_limit;
    int   cycles     = 0;
    int   commit_idx = 0;
    int   mis_count  = 0;
    int   errors     = 0;
    logic prev_mis   = 1'b0;
    logic done       = 1'b0;

    frontend_top #(.PC_SIZE(PC_SIZE), .TABLE_BITS(TABLE_BITS)) dut_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .mispredict   (mispredict),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_wen   (commit_wen)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // walk the program with both models until the final jal
    task automatic build_expected();
        logic [PC_SIZE-1:0] pc;
        logic [PC_SIZE-1:0] next_pc;
        logic               taken;
        logic               stop;
        int                 i;
        for (i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        for (i = 0; i < 2 ** TABLE_BITS; i++) begin
            model_ctr[i] = WEAK_TAKEN;
        end
        pend_valid    = 1'b0;
        pc            = '0;
        stop          = 1'b0;
        exp_count     = 0;
        exp_mis_total = 0;
        while (!stop && exp_count < MAX_COMMITS) begin
            exp_pc[exp_count]  = pc;
            next_pc = isa_step(pc, exp_wen[exp_count], exp_rd[exp_count],
                               exp_val[exp_count], taken);
            exp_mis[exp_count] = predict_miss(pc, taken);
            if (exp_mis[exp_count]) begin
                exp_mis_total++;
            end
            if (exp_wen[exp_count]) begin
                model_regs[exp_rd[exp_count]] = exp_val[exp_count];
            end
            exp_count++;
            stop = (pc == PC_SIZE'(END_PC));
            pc   = next_pc;
        end
    endtask

    task automatic check_commit();
        int k;
        k = commit_idx;
        assert (commit_pc == exp_pc[k] && commit_wen == exp_wen[k]) else begin
            errors++;
            $display("ERR %0t: commit %0d pc %0d wen %0b, expected pc %0d wen %0b",
                     $time, k, commit_pc, commit_wen, exp_pc[k], exp_wen[k]);
        end
        assert (!exp_wen[k] || (commit_rd == exp_rd[k] && commit_value == exp_val[k]))
        else begin
            errors++;
            $display("ERR %0t: commit %0d x%0d = %0h, expected x%0d = %0h",
                     $time, k, commit_rd, commit_value, exp_rd[k], exp_val[k]);
        end
        assert (mispredict == exp_mis[k]) else begin
            errors++;
            $display("ERR %0t: commit %0d at pc %0d mispredict %0b, expected %0b",
                     $time, k, commit_pc, mispredict, exp_mis[k]);
        end
        commit_idx++;
        done = (commit_idx == exp_count);
    endtask

    // first run cycle only fills the buffer
    always @(negedge CLK) begin
        if (run && !done) begin
            cycles++;
            if (commit_valid) begin
                check_commit();
            end else begin
                assert (cycles == 1 || prev_mis) else begin
                    errors++;
                    $display("ERR %0t: bubble before commit %0d with no mispredict",
                             $time, commit_idx);
                end
                assert (!mispredict) else begin
                    errors++;
                    $display("ERR %0t: mispredict raised in a bubble", $time);
                end
            end
            assert (!(prev_mis && commit_valid)) else begin
                errors++;
                $display("ERR %0t: no bubble after a mispredict", $time);
            end
            if (mispredict) begin
                mis_count++;
            end
            prev_mis = mispredict;
        end
    end

    initial begin
        int a;
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_program();
        build_expected();
        cycle_limit = exp_count + exp_mis_total + MARGIN;
        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;
        for (a = 0; a < WORDS; a++) begin
            @(posedge CLK);
            prog_we   <= 1'b1;
            prog_addr <= PC_SIZE'(a);
            prog_data <= prog_word[a];
        end
        @(posedge CLK);
        prog_we <= 1'b0;
        run     <= 1'b1;
        while (!done && cycles < cycle_limit) begin
            @(posedge CLK);
        end
        if (!done) begin
            $display("Run hit the cycle limit of %0d with %0d of %0d commits seen",
                     cycle_limit, commit_idx, exp_count);
        end
        assert (mis_count == exp_mis_total) else begin
            errors++;
            $display("ERR %0t: %0d mispredicts, expected %0d", $time, mis_count, exp_mis_total);
        end
        $display("commits %0d of %0d, mispredicts %0d of %0d, errors %0d",
                 commit_idx, exp_count, mis_count, exp_mis_total, errors);
        if (errors == 0 && done) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+sim
hdl/bp_pkg.sv
hdl/instr_rom.sv
hdl/jump_predictor.sv
hdl/fetch_unit.sv
hdl/fetch_buffer.sv
hdl/branch_resolver.sv
hdl/frontend_top.sv
sim/tb_top.sv
